// ==== design/cft_bus_pkg.sv ====
// CFT backplane shared definitions
// Bus widths, AXI4-Lite field types, memory card map and response codes
// for the bus controller, the memory cards and the bus return stage.

`default_nettype none

package cft_bus_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   localparam int ADDR_W = 24;                // Backplane ab width
   localparam int DATA_W = 16;                // Backplane db width
   localparam int AXI_AW = 32;                // Host byte address
   localparam int AXI_DW = 32;                // Host data word

   //////////////////////////////////////////////////////////////////////
   // Card map
   //////////////////////////////////////////////////////////////////////

   localparam int N_CARDS        = 4;         // Backplane slots
   localparam int CARD_AW        = 8;         // Word address bits per card
   localparam int CARD_WAIT_BASE = 0;         // Slot k adds k on top of this
   localparam int WAIT_CNT_W     = 4;         // Wait-state counter, up to 15

   typedef logic [ADDR_W-1:0]          addr_t;      // Word address on ab
   typedef logic [DATA_W-1:0]          data_t;      // Word on db
   typedef logic [AXI_AW-1:0]          axi_addr_t;
   typedef logic [AXI_DW-1:0]          axi_data_t;
   typedef logic [1:0]                 axi_resp_t;
   typedef logic [CARD_AW-1:0]         word_idx_t;  // Offset inside one card
   typedef logic [$clog2(N_CARDS)-1:0] card_idx_t;  // Slot field above the offset

   localparam axi_resp_t RESP_OKAY   = 2'd0;
   localparam axi_resp_t RESP_DECERR = 2'd3;        // Nobody claimed the address

   // Bus controller card sequencing
   typedef enum logic [1:0] {
      st_idle,                                // Waiting for a host request
      st_bus,                                 // Memory cycle on the backplane
      st_resp                                 // Response held for the host
   } bridge_state_t;

endpackage

`default_nettype wire

// ==== design/bus_axil_bridge.sv ====
// Bus controller card
// AXI4-Lite slave facing the host. Each accepted transaction becomes one
// backplane memory cycle: strobes go low the cycle after the handshake,
// stay low until the return stage reports completion, then the response
// is held on the B or R channel until the host takes it.

`default_nettype none

module bus_axil_bridge
   import cft_bus_pkg::*;
(
   input  wire            clk,
   input  wire            rst_n,
   // Write address / data / response
   input  wire axi_addr_t awaddr,
   input  wire            awvalid,
   output logic           awready,
   input  wire axi_data_t wdata,
   input  wire [3:0]      wstrb,             // Word bus only, lanes ignored
   input  wire            wvalid,
   output logic           wready,
   output axi_resp_t      bresp,
   output logic           bvalid,
   input  wire            bready,
   // Read address / data
   input  wire axi_addr_t araddr,
   input  wire            arvalid,
   output logic           arready,
   output axi_data_t      rdata,
   output axi_resp_t      rresp,
   output logic           rvalid,
   input  wire            rready,
   // Backplane side
   output logic           nmem,
   output logic           nr,
   output logic           nw,
   output addr_t          ab,
   output data_t          db_out,
   input  wire            bus_done,
   input  wire            bus_err,
   input  wire data_t     bus_rdata
);

   bridge_state_t state;
   logic          wr_go;                     // Write accepted this cycle
   logic          rd_go;                     // Read accepted this cycle
   logic          resp_taken;                // Host took B or R

   // Write needs both AW and W, and beats a pending read
   assign wr_go      = (state == st_idle) && awvalid && wvalid;
   assign rd_go      = (state == st_idle) && arvalid && !wr_go;
   assign resp_taken = (bvalid && bready) || (rvalid && rready);

   assign awready = wr_go;                   // AW and W taken together
   assign wready  = wr_go;
   assign arready = rd_go;

   //////////////////////////////////////////////////////////////////////
   // Control FSM and strobes
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= st_idle;
         nmem   <= 1'b1;                     // Backplane idle
         nr     <= 1'b1;
         nw     <= 1'b1;
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (wr_go) begin
                  nmem  <= 1'b0;             // Write cycle starts next cycle
                  nw    <= 1'b0;
                  state <= st_bus;
               end else if (rd_go) begin
                  nmem  <= 1'b0;             // Read cycle
                  nr    <= 1'b0;
                  state <= st_bus;
               end
            end
            st_bus: begin
               if (bus_done) begin
                  nmem   <= 1'b1;            // End of cycle, release bus
                  nr     <= 1'b1;
                  nw     <= 1'b1;
                  bvalid <= !nw;             // Pick channel from cycle kind
                  rvalid <= !nr;
                  state  <= st_resp;
               end
            end
            st_resp: begin
               if (resp_taken) begin
                  bvalid <= 1'b0;
                  rvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Address, write data and response payload
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_go) begin
         ab     <= awaddr[ADDR_W:1];         // Byte to word address
         db_out <= wdata[DATA_W-1:0];        // Low half only
      end else if (rd_go) begin
         ab <= araddr[ADDR_W:1];
      end
      if ((state == st_bus) && bus_done) begin
         bresp <= bus_err ? RESP_DECERR : RESP_OKAY;
         rresp <= bus_err ? RESP_DECERR : RESP_OKAY;
         rdata <= bus_err ? '0 : axi_data_t'(bus_rdata); // Upper half zero
      end
   end

   // Read and write strobes are exclusive on the backplane
   a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
      nr || nw);

   // Memory strobe held for the whole bus cycle, until the return stage ends it
   a_nmem_held: assert property (@(posedge clk) disable iff (!rst_n)
      (state == st_bus) |-> !nmem);

endmodule

`default_nettype wire

// ==== design/card_mem.sv ====
// Memory card
// 256-word RAM behind a window decoder. The card claims a memory cycle
// when the slot field of ab matches its slot and all higher bits are
// zero, pulls its wait line low for WAIT_STATES cycles, then completes
// the write or drives the addressed word back to the return stage.

`default_nettype none

module card_mem
   import cft_bus_pkg::*;
#(
   parameter card_idx_t SLOT        = '0,
   parameter int        WAIT_STATES = 0      // Must fit WAIT_CNT_W bits
) (
   input  wire        clk,
   input  wire        rst_n,
   input  wire        nmem,
   input  wire        nr,
   input  wire        nw,
   input  wire addr_t ab,
   input  wire data_t db_out,
   output logic       card_sel,
   output logic       nws_card,              // Open-drain nws, one per card
   output data_t      card_rdata
);

   data_t                 mem [0:(1 << CARD_AW)-1];
   word_idx_t             idx;               // Word inside this card
   logic                  hit;               // Window match on ab
   logic                  waiting;           // Still stretching the cycle
   logic                  complete;          // Claimed and wait states done
   logic [WAIT_CNT_W-1:0] wait_cnt;

   assign idx = ab[CARD_AW-1:0];

   // Upper ab bits must equal the slot number exactly, zeros above it
   assign hit = (ab[ADDR_W-1:CARD_AW] == (ADDR_W-CARD_AW)'(SLOT));

   assign card_sel = !nmem && hit;
   assign waiting  = card_sel && (wait_cnt != '0);
   assign nws_card = !waiting;               // Low pulls nws down
   assign complete = card_sel && !waiting;

   //////////////////////////////////////////////////////////////////////
   // Wait-state generator
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wait_cnt <= WAIT_CNT_W'(WAIT_STATES);
      end else if (nmem) begin
         wait_cnt <= WAIT_CNT_W'(WAIT_STATES); // Reload between cycles
      end else if (waiting) begin
         wait_cnt <= wait_cnt - 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // RAM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (complete && !nw) begin
         mem[idx] <= db_out;                 // Write lands at completion
      end
   end

   // Word sampled by the return stage in the completion cycle
   assign card_rdata = (card_sel && !nr) ? mem[idx] : '0;

   // No card may hold nws down outside a memory cycle
   a_nws_idle: assert property (@(posedge clk) disable iff (!rst_n)
      nmem |-> nws_card);

endmodule

`default_nettype wire

// ==== design/bus_return.sv ====
// Bus return stage
// Wired-AND of the card wait lines and OR of their read data. Ends each
// memory cycle in the first cycle with nmem low and nws released, and
// reports done, decode error and read data to the controller, registered.

`default_nettype none

module bus_return
   import cft_bus_pkg::*;
(
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      nmem,
   input  wire [N_CARDS-1:0]        card_sel,
   input  wire [N_CARDS-1:0]        nws_card,
   input  wire data_t [N_CARDS-1:0] card_rdata,
   output logic                     bus_done,
   output logic                     bus_err,
   output data_t                    bus_rdata
);

   logic  nws_all;                           // Resolved open-drain nws
   logic  any_sel;                           // Some card claimed ab
   logic  cycle_end;                         // Completion seen this cycle
   logic  done_seen;                         // Already reported this cycle
   data_t rdata_or;

   assign nws_all   = &nws_card;
   assign any_sel   = |card_sel;
   assign cycle_end = !nmem && nws_all && !done_seen;

   // Unselected cards drive zero, so OR acts as the data bus
   always_comb begin
      rdata_or = '0;
      for (int i = 0; i < N_CARDS; i++) begin
         rdata_or = rdata_or | card_rdata[i];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         done_seen <= 1'b0;
         bus_done  <= 1'b0;
         bus_err   <= 1'b0;
      end else begin
         done_seen <= !nmem && (done_seen || cycle_end); // Cleared on release
         bus_done  <= cycle_end;                         // One-cycle pulse
         if (cycle_end) begin
            bus_err <= !any_sel;                         // Unmapped address
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cycle_end) begin
         bus_rdata <= rdata_or;
      end
   end

   // Card windows never overlap
   a_one_card: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(card_sel));

endmodule

`default_nettype wire

// ==== design/cft_backplane.sv ====
// CFT backplane slice
// Bus controller card, four memory cards in slots 0 to 3 and the bus
// return stage. Slot k stretches its cycles by CARD_WAIT_BASE + k waits.

`default_nettype none

module cft_backplane
   import cft_bus_pkg::*;
(
   input  wire            clk,
   input  wire            rst_n,
   input  wire axi_addr_t awaddr,
   input  wire            awvalid,
   output wire            awready,
   input  wire axi_data_t wdata,
   input  wire [3:0]      wstrb,
   input  wire            wvalid,
   output wire            wready,
   output wire axi_resp_t bresp,
   output wire            bvalid,
   input  wire            bready,
   input  wire axi_addr_t araddr,
   input  wire            arvalid,
   output wire            arready,
   output wire axi_data_t rdata,
   output wire axi_resp_t rresp,
   output wire            rvalid,
   input  wire            rready
);

   //////////////////////////////////////////////////////////////////////
   // Backplane nets
   //////////////////////////////////////////////////////////////////////

   wire                      nmem;           // Memory cycle strobe
   wire                      nr;             // Read strobe
   wire                      nw;             // Write strobe
   wire addr_t               ab;             // 24-bit address bus
   wire data_t               db_out;         // Write data from the controller
   wire [N_CARDS-1:0]        card_sel;
   wire [N_CARDS-1:0]        nws_card;       // Per-card open-drain nws
   wire data_t [N_CARDS-1:0] card_rdata;
   wire                      bus_done;
   wire                      bus_err;
   wire data_t               bus_rdata;

   bus_axil_bridge u_bridge (
      .clk(clk), .rst_n(rst_n),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .nmem(nmem), .nr(nr), .nw(nw), .ab(ab), .db_out(db_out),
      .bus_done(bus_done), .bus_err(bus_err), .bus_rdata(bus_rdata)
   );

   // Memory card slots
   for (genvar k = 0; k < N_CARDS; k++) begin : g_slot
      card_mem #(
         .SLOT(card_idx_t'(k)),
         .WAIT_STATES(CARD_WAIT_BASE + k)    // Slower cards further out
      ) u_card (
         .clk(clk), .rst_n(rst_n),
         .nmem(nmem), .nr(nr), .nw(nw), .ab(ab), .db_out(db_out),
         .card_sel(card_sel[k]), .nws_card(nws_card[k]),
         .card_rdata(card_rdata[k])
      );
   end

   bus_return u_return (
      .clk(clk), .rst_n(rst_n), .nmem(nmem),
      .card_sel(card_sel), .nws_card(nws_card), .card_rdata(card_rdata),
      .bus_done(bus_done), .bus_err(bus_err), .bus_rdata(bus_rdata)
   );

endmodule

`default_nettype wire

// ==== verification/tb_cft_backplane.sv ====
// Testbench for the CFT backplane slice
// Directed AXI4-Lite tests against a shadow memory model: card windows,
// wait-state latency, address decode, response back-pressure, write/read
// priority and random mixed traffic.

`default_nettype none

module tb_cft_backplane
   import cft_bus_pkg::*;
();

   localparam int N_TRANS        = 16 + 8 + 14 + 8 + 3 + 64; // Per test, in run order
   localparam int TIMEOUT_CYCLES = N_TRANS * 40 + 200;

   logic           clk;
   logic           rst_n;
   axi_addr_t      awaddr;
   axi_addr_t      araddr;
   axi_data_t      wdata;
   logic [3:0]     wstrb;
   logic           awvalid;
   logic           wvalid;
   logic           bready;
   logic           arvalid;
   logic           rready;
   wire            awready;
   wire            wready;
   wire            bvalid;
   wire            arready;
   wire            rvalid;
   wire axi_resp_t bresp;
   wire axi_resp_t rresp;
   wire axi_data_t rdata;

   data_t          shadow [addr_t];          // Expected card contents per word
   logic [31:0]    rng = 32'd8384;
   int             cycle_cnt;

   cft_backplane uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Hang guard
   initial begin
      cycle_cnt = 0;
      forever begin
         @(posedge clk);
         cycle_cnt++;
         if (cycle_cnt > TIMEOUT_CYCLES)
            fail_run($sformatf("Timeout: no progress within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers and checks
   //////////////////////////////////////////////////////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) fail_run($sformatf("ERR %s: expected %h actual %h", name, exp, act));
   endtask

   task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
      if (act !== exp) fail_run($sformatf("ERR %s: expected %0d actual %0d", name, exp, act));
   endtask

   task automatic check_latency(input string name, input int exp, input int act);
      if (act != exp) fail_run($sformatf("ERR %s: expected %0d actual %0d", name, exp, act));
   endtask

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Byte address of word w on card k
   function automatic axi_addr_t card_addr(input int k, input int w);
      return axi_addr_t'(((k << CARD_AW) | w) << 1);
   endfunction

   function automatic logic is_mapped(input axi_addr_t a);
      return a[ADDR_W:CARD_AW+3] == '0;      // Word bits above the slot field
   endfunction

   // Handshake to valid: k waits plus 3, unclaimed as slot 0
   function automatic int expected_latency(input axi_addr_t a);
      if (!is_mapped(a)) return 3;
      return int'(a[CARD_AW+1 +: 2]) + CARD_WAIT_BASE + 3;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // AXI4-Lite transactions
   //////////////////////////////////////////////////////////////////////

   task automatic axil_write(input axi_addr_t a, input axi_data_t d, input int hold,
                             output axi_resp_t resp, output int lat);
      @(negedge clk);
      awaddr  = a;
      wdata   = d;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = (hold == 0);
      do begin
         @(posedge clk);
      end while (!(awready && wready));
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      lat     = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!bvalid);
      resp = bresp;
      if (hold > 0) begin
         @(negedge clk);
         awvalid = 1'b1;                     // Competing requests while B waits
         wvalid  = 1'b1;
         arvalid = 1'b1;
         repeat (hold) begin
            @(posedge clk);
            if (!bvalid || bresp !== resp) fail_run("B channel changed while bready was low");
            if (awready || wready || arready)
               fail_run("Request accepted while a write response was pending");
         end
         @(negedge clk);
         awvalid = 1'b0;
         wvalid  = 1'b0;
         arvalid = 1'b0;
         bready  = 1'b1;
         @(posedge clk);                     // Response taken
      end
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axil_read(input axi_addr_t a, input int hold, output axi_data_t rd,
                            output axi_resp_t resp, output int lat);
      @(negedge clk);
      araddr  = a;
      arvalid = 1'b1;
      rready  = (hold == 0);
      do begin
         @(posedge clk);
      end while (!arready);
      @(negedge clk);
      arvalid = 1'b0;
      lat     = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!rvalid);
      rd   = rdata;
      resp = rresp;
      if (hold > 0) begin
         @(negedge clk);
         awvalid = 1'b1;                     // Competing requests while R waits
         wvalid  = 1'b1;
         arvalid = 1'b1;
         repeat (hold) begin
            @(posedge clk);
            if (!rvalid || rdata !== rd || rresp !== resp)
               fail_run("R channel changed while rready was low");
            if (awready || wready || arready)
               fail_run("Request accepted while a read response was pending");
         end
         @(negedge clk);
         awvalid = 1'b0;
         wvalid  = 1'b0;
         arvalid = 1'b0;
         rready  = 1'b1;
         @(posedge clk);
      end
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic write_and_verify(input string name, input axi_addr_t a, input data_t d,
                                   input int hold);
      axi_resp_t resp;
      int        lat;
      axil_write(a, {~d, d}, hold, resp, lat); // Upper half must be dropped
      check_resp(name, is_mapped(a) ? RESP_OKAY : RESP_DECERR, resp);
      check_latency(name, expected_latency(a), lat);
      if (is_mapped(a)) shadow[a[ADDR_W:1]] = d;
   endtask

   task automatic read_and_verify(input string name, input axi_addr_t a, input int hold);
      axi_data_t rd;
      axi_resp_t resp;
      int        lat;
      axil_read(a, hold, rd, resp, lat);
      check_resp(name, is_mapped(a) ? RESP_OKAY : RESP_DECERR, resp);
      check_latency(name, expected_latency(a), lat);
      check_data(name, '0, rd[31:16]);
      check_data(name, is_mapped(a) ? shadow[a[ADDR_W:1]] : '0, rd[15:0]);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic card_words_roundtrip();
      for (int k = 0; k < N_CARDS; k++) begin
         write_and_verify("card_words_wr", card_addr(k, 0), data_t'((k + 1) * 4096), 0);
         write_and_verify("card_words_wr", card_addr(k, 255), data_t'((k + 1) * 4096 + 255), 0);
      end
      for (int k = 0; k < N_CARDS; k++) begin
         read_and_verify("card_words_rd", card_addr(k, 0), 0);
         read_and_verify("card_words_rd", card_addr(k, 255), 0);
      end
   endtask

   task automatic wait_state_latency();
      for (int k = 0; k < N_CARDS; k++) begin
         write_and_verify("wait_states_wr", card_addr(k, 16), data_t'(32'hC000 + k), 0);
         read_and_verify("wait_states_rd", card_addr(k, 16), 0);
      end
   endtask

   task automatic decode_errors();
      axi_addr_t bad [3];
      bad[0] = card_addr(0, 0) | (32'd1 << 11);   // Word bit 10
      bad[1] = card_addr(3, 255) | (32'd1 << 24); // Word bit 23
      bad[2] = card_addr(1, 0) | (32'd1 << 17);
      for (int i = 0; i < 3; i++) begin
         write_and_verify("decode_wr", bad[i], 16'hDEAD, 0);
         read_and_verify("decode_rd", bad[i], 0);
      end
      for (int k = 0; k < N_CARDS; k++) begin  // Aliased words untouched
         read_and_verify("decode_keep", card_addr(k, 0), 0);
         read_and_verify("decode_keep", card_addr(k, 255), 0);
      end
   endtask

   task automatic response_backpressure();
      for (int k = 0; k < N_CARDS; k++) begin
         write_and_verify("bp_wr", card_addr(k, 32), data_t'(next_rand()),
                          int'(next_rand() % 8) + 1);
         read_and_verify("bp_rd", card_addr(k, 32), int'(next_rand() % 8) + 1);
      end
   endtask

   task automatic priority_and_mixed();
      axi_addr_t   a;
      logic [31:0] r;
      a = card_addr(1, 48);
      write_and_verify("prio_pre", a, 16'h1111, 0);
      @(negedge clk);
      awaddr  = a;
      wdata   = 32'h0000_BEEF;
      araddr  = a;
      awvalid = 1'b1;                        // All three in the same cycle
      wvalid  = 1'b1;
      arvalid = 1'b1;
      bready  = 1'b1;
      rready  = 1'b1;
      @(posedge clk);
      if (!(awready && wready) || arready) fail_run("Write did not win over a concurrent read");
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      do begin
         @(posedge clk);
      end while (!bvalid && !rvalid);
      if (!bvalid) fail_run("Read response returned before the write response");
      check_resp("prio_b", RESP_OKAY, bresp);
      shadow[a[ADDR_W:1]] = 16'hBEEF;
      do begin
         @(posedge clk);
      end while (!arready);
      @(negedge clk);
      arvalid = 1'b0;
      do begin
         @(posedge clk);
      end while (!rvalid);
      check_resp("prio_r", RESP_OKAY, rresp);
      check_data("prio_r", 16'hBEEF, rdata[15:0]);
      @(negedge clk);
      bready = 1'b0;
      rready = 1'b0;
      repeat (64) begin                      // Random mapped traffic
         r = next_rand();
         a = card_addr(int'(r[1:0]), int'(r[9:2]));
         if (r[10] || !shadow.exists(a[ADDR_W:1]))
            write_and_verify("mixed_wr", a, r[31:16], 0);
         else
            read_and_verify("mixed_rd", a, 0);
      end
   endtask

   initial begin
      rst_n   = 1'b0;
      awaddr  = '0;
      araddr  = '0;
      wdata   = '0;
      wstrb   = 4'hF;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      card_words_roundtrip();
      wait_state_latency();
      decode_errors();
      response_backpressure();
      priority_and_mixed();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/cft_bus_pkg.sv
design/bus_axil_bridge.sv
design/card_mem.sv
design/bus_return.sv
design/cft_backplane.sv
verification/tb_cft_backplane.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CFT backplane testbench with Verilator and run it

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_cft_backplane -f filelist.f --Mdir obj_dir ||
   { echo "Build failed"; exit 1; }

out=$(./obj_dir/Vtb_cft_backplane 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qF '*** PASSED ***' &&
   echo "Simulation passed" ||
   { echo "Simulation failed"; exit 1; }
